/* corr_pkg.sv */
/*
 * sizes shared by the lag correlator
 * baseline pair lookup functions
 * product operation and readout state encodings
 */

package corr_pkg;

	// ====================================================================
	// sizes
	// ====================================================================
	localparam int NUM_INPUTS     = 4;
	localparam int NUM_BASELINES  = NUM_INPUTS * (NUM_INPUTS - 1) / 2; // every unordered pair
	localparam int WORD_WIDTH     = 2;
	localparam int LINE_DEPTH     = 8;
	localparam int LAG_WIDTH      = 3;
	localparam int RESOLUTION     = 10;
	localparam int BL_INDEX_WIDTH = $clog2(NUM_BASELINES);

	// one full-scale sample of headroom below the signed maximum
	localparam int MAX_COUNTS = (2 ** (RESOLUTION - 1) - 1) - (2 ** WORD_WIDTH - 1);

	// ====================================================================
	// baseline pair table, walked in order (0,1) (0,2) .. (2,3)
	// ====================================================================
	function automatic int baseline_input(input int index, input bit second);
		int count;
		int result;
		count = 0;
		result = 0;
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				if (count == index)
					result = second ? b : a;
				count++;
			end
		end
		return result;
	endfunction

	function automatic int baseline_first(input int index);
		return baseline_input(index, 1'b0);
	endfunction

	function automatic int baseline_second(input int index);
		return baseline_input(index, 1'b1);
	endfunction

	typedef enum logic {OP_MULTIPLY, OP_DIFFERENCE} corr_op_e;

	typedef enum logic [1:0] {RD_IDLE, RD_SNAP, RD_SEND} rd_state_e;

endpackage

/* sample_capture.sv */
/*
 * strobe toggle detection and sample latching
 * per-input delay lines and the common sample tick
 */

`timescale 1ns/10ps

module sample_capture import corr_pkg::*; (
	input  logic                                        clk,
	input  logic                                        arst_n_i,
	input  logic [NUM_INPUTS-1:0]                       sample_strobe_i,
	input  logic [NUM_INPUTS*WORD_WIDTH-1:0]            sample_data_i,
	output logic [NUM_INPUTS*LINE_DEPTH*WORD_WIDTH-1:0] taps_o,
	output logic                                        tick_o
);

	logic [NUM_INPUTS-1:0]            strobe_q; // last seen strobe levels
	logic                             primed_q;
	logic [NUM_INPUTS-1:0]            toggle_q;
	logic [NUM_INPUTS*WORD_WIDTH-1:0] data_q;
	logic [WORD_WIDTH-1:0]            line_q [NUM_INPUTS][LINE_DEPTH];

	// ====================================================================
	// toggle detection
	// ====================================================================

	// the first edge after reset only loads the history, so a strobe
	// that is already high does not count as a toggle
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			strobe_q <= '0;
			primed_q <= 1'b0;
			toggle_q <= '0;
		end else begin
			strobe_q <= sample_strobe_i;
			primed_q <= 1'b1;
			toggle_q <= primed_q ? (sample_strobe_i ^ strobe_q) : '0;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= sample_data_i; // sample taken on the same edge as its toggle
	end

	// ====================================================================
	// delay lines
	// ====================================================================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				for (int t = 0; t < LINE_DEPTH; t++) begin
					line_q[i][t] <= '0;
				end
			end
			tick_o <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				if (toggle_q[i]) begin
					line_q[i][0] <= data_q[i*WORD_WIDTH +: WORD_WIDTH];
					for (int t = 1; t < LINE_DEPTH; t++) begin
						line_q[i][t] <= line_q[i][t-1]; // older samples move one tap along
					end
				end
			end
			tick_o <= |toggle_q; // high while the new taps are visible
		end
	end

	// tap t of input i sits at word i*LINE_DEPTH + t
	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int t = 0; t < LINE_DEPTH; t++) begin
				taps_o[(i*LINE_DEPTH + t)*WORD_WIDTH +: WORD_WIDTH] = line_q[i][t];
			end
		end
	end

endmodule

/* baseline_cell.sv */
/*
 * I/Q product stage for one pair of inputs
 * saturating signed accumulators
 */

`timescale 1ns/10ps

module baseline_cell import corr_pkg::*; #(
	parameter int BASELINE = 0 // index into the baseline pair table
) (
	input  logic                                       clk,
	input  logic                                       arst_n_i,
	input  logic                                       enable_i,
	input  logic                                       tick_i,
	input  logic [NUM_INPUTS*LINE_DEPTH*WORD_WIDTH-1:0] taps_i,
	input  logic [NUM_INPUTS*LAG_WIDTH-1:0]            lag_i,
	input  logic [NUM_INPUTS-1:0]                      op_mask_i,
	input  logic                                       clear_i,
	output logic signed [RESOLUTION-1:0]               acc_i_o,
	output logic signed [RESOLUTION-1:0]               acc_q_o
);

	logic [LAG_WIDTH-1:0]         lag_full;
	logic [LAG_WIDTH-1:0]         lag_half;
	logic [WORD_WIDTH-1:0]        cur_word;
	logic [WORD_WIDTH-1:0]        half_word;
	logic [WORD_WIDTH-1:0]        full_word;
	logic signed [RESOLUTION-1:0] cur_s;
	logic signed [RESOLUTION-1:0] half_s;
	logic signed [RESOLUTION-1:0] full_s;
	logic signed [RESOLUTION-1:0] res_i;
	logic signed [RESOLUTION-1:0] res_q;
	logic signed [RESOLUTION-1:0] prod_i_q;
	logic signed [RESOLUTION-1:0] prod_q_q;
	logic                         prod_valid_q;
	corr_op_e                     op;

	// adds and clamps to the signed range instead of wrapping
	function automatic logic signed [RESOLUTION-1:0] sat_add(
		input logic signed [RESOLUTION-1:0] acc,
		input logic signed [RESOLUTION-1:0] inc
	);
		logic signed [RESOLUTION:0] sum;
		sum = acc + inc;
		if (sum[RESOLUTION] != sum[RESOLUTION-1])
			return sum[RESOLUTION] ? {1'b1, {(RESOLUTION-1){1'b0}}} : {1'b0, {(RESOLUTION-1){1'b1}}};
		return sum[RESOLUTION-1:0];
	endfunction

	// ====================================================================
	// tap selection and product rule
	// ====================================================================
	always_comb begin
		lag_full  = lag_i[baseline_second(BASELINE)*LAG_WIDTH +: LAG_WIDTH];
		lag_half  = lag_full >> 1; // I looks half as far back as Q
		cur_word  = taps_i[baseline_first(BASELINE)*LINE_DEPTH*WORD_WIDTH +: WORD_WIDTH];
		half_word = taps_i[(baseline_second(BASELINE)*LINE_DEPTH + lag_half)*WORD_WIDTH +: WORD_WIDTH];
		full_word = taps_i[(baseline_second(BASELINE)*LINE_DEPTH + lag_full)*WORD_WIDTH +: WORD_WIDTH];
		cur_s  = signed'(RESOLUTION'(cur_word));
		half_s = signed'(RESOLUTION'(half_word));
		full_s = signed'(RESOLUTION'(full_word));
		op = (op_mask_i[baseline_first(BASELINE)] && op_mask_i[baseline_second(BASELINE)])
			? OP_MULTIPLY : OP_DIFFERENCE;
		case (op)
			OP_MULTIPLY: begin
				res_i = cur_s * half_s;
				res_q = cur_s * full_s;
			end
			default: begin
				res_i = cur_s - half_s;
				res_q = cur_s - full_s;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (tick_i) begin
			prod_i_q <= res_i;
			prod_q_q <= res_q;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			prod_valid_q <= 1'b0;
		else
			prod_valid_q <= tick_i;
	end

	// ====================================================================
	// accumulators, frozen once either one reaches MAX_COUNTS
	// ====================================================================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_i_o <= '0;
			acc_q_o <= '0;
		end else if (!enable_i || clear_i) begin
			acc_i_o <= '0;
			acc_q_o <= '0;
		end else if (prod_valid_q && acc_i_o < MAX_COUNTS && acc_q_o < MAX_COUNTS) begin
			acc_i_o <= sat_add(acc_i_o, prod_i_q);
			acc_q_o <= sat_add(acc_q_o, prod_q_q);
		end
	end

endmodule

/* readout_serializer.sv */
/*
 * dump snapshot of every baseline accumulator and cell clear
 * valid/ready streaming of one word per baseline
 */

`timescale 1ns/10ps

module readout_serializer import corr_pkg::*; (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic                                dump_i,
	input  logic [NUM_BASELINES*RESOLUTION-1:0] acc_i_i,
	input  logic [NUM_BASELINES*RESOLUTION-1:0] acc_q_i,
	input  logic                                out_ready_i,
	output logic                                clear_o,
	output logic                                out_valid_o,
	output logic [BL_INDEX_WIDTH-1:0]           out_index_o,
	output logic signed [RESOLUTION-1:0]        out_i_o,
	output logic signed [RESOLUTION-1:0]        out_q_o,
	output logic                                busy_o
);

	rd_state_e                 state_q;
	logic [BL_INDEX_WIDTH-1:0] index_q; // baseline currently on the output
	logic [RESOLUTION-1:0]     bank_i [NUM_BASELINES];
	logic [RESOLUTION-1:0]     bank_q [NUM_BASELINES];
	logic                      handshake;
	logic                      last_word;

	// ====================================================================
	// readout FSM
	// ====================================================================

	// dump_i is only looked at in RD_IDLE, so a dump during a readout is dropped
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= RD_IDLE;
			index_q <= '0;
		end else begin
			case (state_q)
				RD_IDLE: begin
					if (dump_i)
						state_q <= RD_SNAP;
				end
				RD_SNAP: begin
					state_q <= RD_SEND;
					index_q <= '0;
				end
				RD_SEND: begin
					if (handshake) begin
						if (last_word)
							state_q <= RD_IDLE;
						else
							index_q <= index_q + 1'b1;
					end
				end
				default: begin
					state_q <= RD_IDLE;
				end
			endcase
		end
	end

	// ====================================================================
	// snapshot bank
	// ====================================================================

	// the copy and the cell clear act on the same edge, so nothing
	// accumulated before the snapshot is counted twice
	always_ff @(posedge clk) begin
		if (state_q == RD_SNAP) begin
			for (int b = 0; b < NUM_BASELINES; b++) begin
				bank_i[b] <= acc_i_i[b*RESOLUTION +: RESOLUTION];
				bank_q[b] <= acc_q_i[b*RESOLUTION +: RESOLUTION];
			end
		end
	end

	assign busy_o      = (state_q != RD_IDLE);
	assign clear_o     = (state_q == RD_SNAP); // one cycle wide by construction
	assign out_valid_o = (state_q == RD_SEND);

	assign handshake = out_valid_o && out_ready_i;
	assign last_word = (index_q == BL_INDEX_WIDTH'(NUM_BASELINES - 1));

	// bank and index only move on a handshake, which keeps the word stable under back-pressure
	assign out_index_o = index_q;
	assign out_i_o     = bank_i[index_q];
	assign out_q_o     = bank_q[index_q];

endmodule

/* correlator_top.sv */
/*
 * lag correlator top level
 * capture block, one cell per baseline and the readout serializer
 */

`timescale 1ns/10ps

module correlator_top import corr_pkg::*; (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  logic                            enable_i,
	input  logic [NUM_INPUTS-1:0]           sample_strobe_i,
	input  logic [NUM_INPUTS*WORD_WIDTH-1:0] sample_data_i,
	input  logic [NUM_INPUTS*LAG_WIDTH-1:0] lag_i,
	input  logic [NUM_INPUTS-1:0]           op_mask_i,
	input  logic                            dump_i,
	input  logic                            out_ready_i,
	output logic                            out_valid_o,
	output logic [BL_INDEX_WIDTH-1:0]       out_index_o,
	output logic signed [RESOLUTION-1:0]    out_i_o,
	output logic signed [RESOLUTION-1:0]    out_q_o,
	output logic                            busy_o
);

	logic [NUM_INPUTS*LINE_DEPTH*WORD_WIDTH-1:0] taps;
	logic                                        tick;
	logic                                        snap_clear;
	logic [NUM_BASELINES*RESOLUTION-1:0]         acc_i_all;
	logic [NUM_BASELINES*RESOLUTION-1:0]         acc_q_all;

	sample_capture u_capture (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.sample_strobe_i (sample_strobe_i),
		.sample_data_i   (sample_data_i),
		.taps_o          (taps),
		.tick_o          (tick)
	);

	// ====================================================================
	// one cell per baseline, pair picked by the loop index
	// ====================================================================
	for (genvar b = 0; b < NUM_BASELINES; b++) begin : g_cell
		baseline_cell #(.BASELINE(b)) u_cell (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.enable_i  (enable_i),
			.tick_i    (tick),
			.taps_i    (taps),
			.lag_i     (lag_i),
			.op_mask_i (op_mask_i),
			.clear_i   (snap_clear),
			.acc_i_o   (acc_i_all[b*RESOLUTION +: RESOLUTION]),
			.acc_q_o   (acc_q_all[b*RESOLUTION +: RESOLUTION])
		);
	end

	readout_serializer u_readout (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.dump_i      (dump_i),
		.acc_i_i     (acc_i_all),
		.acc_q_i     (acc_q_all),
		.out_ready_i (out_ready_i),
		.clear_o     (snap_clear),
		.out_valid_o (out_valid_o),
		.out_index_o (out_index_o),
		.out_i_o     (out_i_o),
		.out_q_o     (out_q_o),
		.busy_o      (busy_o)
	);

endmodule

/* correlator_checker.sv */
/*
 * concurrent assertions on the readout handshake of correlator_top
 */

`timescale 1ns/10ps

module correlator_checker import corr_pkg::*; (
	input logic                          clk,
	input logic                          arst_n_i,
	input logic                          valid_i,
	input logic                          ready_i,
	input logic [BL_INDEX_WIDTH-1:0]     index_i,
	input logic signed [RESOLUTION-1:0]  i_word_i,
	input logic signed [RESOLUTION-1:0]  q_word_i,
	input logic                          busy_i
);

	int fail_count = 0; // read by the testbench at the end of the run

	a_no_valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_i)
		else begin
			$error("out_valid_o high during reset");
			fail_count++;
		end

	// a stalled word must not move until it is taken
	a_stable_under_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		(valid_i && !ready_i) |=> (valid_i && $stable(index_i) && $stable(i_word_i)
		&& $stable(q_word_i)))
		else begin
			$error("output word changed while stalled");
			fail_count++;
		end

	a_busy_with_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> busy_i)
		else begin
			$error("out_valid_o high while busy_o is low");
			fail_count++;
		end

	a_index_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		index_i <= BL_INDEX_WIDTH'(NUM_BASELINES - 1))
		else begin
			$error("out_index_o beyond the last baseline");
			fail_count++;
		end

endmodule

/* tb_clock_gen.sv */
/*
 * testbench clock, 8 ns period
 * active low reset held for the first 5 cycles
 */

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n_o
);

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n_o = 1'b1; // release away from the clock edge
	end

endmodule

/* correlator_tb.sv */
/*
 * testbench for correlator_top
 * stimulus, reference model of delay lines and accumulators, scoreboard
 * watchdog and final report
 */

`timescale 1ns/10ps

module correlator_tb import corr_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int TICK_GAP = 4;      // cycles between strobe toggles
	localparam int DUMP_LIMIT = 100;  // cycles allowed for one readout
	localparam int TOTAL_TICKS = 2 + 10 + 12 + 60 + 32 + 5;
	localparam int TOTAL_DUMPS = 7;
	localparam int WATCHDOG_CYCLES = 5 + TOTAL_TICKS * TICK_GAP
		+ TOTAL_DUMPS * (DUMP_LIMIT + 4) + 400;
	localparam int ACC_MAX = 2 ** (RESOLUTION - 1) - 1;
	localparam int ACC_MIN = -(2 ** (RESOLUTION - 1));

	logic                               clk;
	logic                               arst_n_i;
	logic                               enable_i;
	logic [NUM_INPUTS-1:0]              sample_strobe_i;
	logic [NUM_INPUTS*WORD_WIDTH-1:0]   sample_data_i;
	logic [NUM_INPUTS*LAG_WIDTH-1:0]    lag_i;
	logic [NUM_INPUTS-1:0]              op_mask_i;
	logic                               dump_i;
	logic                               out_ready_i;
	logic                               out_valid_o;
	logic [BL_INDEX_WIDTH-1:0]          out_index_o;
	logic signed [RESOLUTION-1:0]       out_i_o;
	logic signed [RESOLUTION-1:0]       out_q_o;
	logic                               busy_o;

	integer seed = 32'h27d6ece5;
	int     error_count = 0;
	int     model_line [NUM_INPUTS][LINE_DEPTH];
	int     acc_i_ref [NUM_BASELINES];
	int     acc_q_ref [NUM_BASELINES];
	int     pair_a [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
	int     pair_b [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};
	int     lag_ref [NUM_INPUTS];
	bit     mask_ref [NUM_INPUTS];
	bit     enable_ref;
	int     k;
	logic [NUM_INPUTS-1:0]            which;
	logic [NUM_INPUTS*WORD_WIDTH-1:0] d;

	tb_clock_gen u_clock (
		.clk      (clk),
		.arst_n_o (arst_n_i)
	);

	correlator_top UUT (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.enable_i        (enable_i),
		.sample_strobe_i (sample_strobe_i),
		.sample_data_i   (sample_data_i),
		.lag_i           (lag_i),
		.op_mask_i       (op_mask_i),
		.dump_i          (dump_i),
		.out_ready_i     (out_ready_i),
		.out_valid_o     (out_valid_o),
		.out_index_o     (out_index_o),
		.out_i_o         (out_i_o),
		.out_q_o         (out_q_o),
		.busy_o          (busy_o)
	);

	bind correlator_top correlator_checker u_checker (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.valid_i  (out_valid_o),
		.ready_i  (out_ready_i),
		.index_i  (out_index_o),
		.i_word_i (out_i_o),
		.q_word_i (out_q_o),
		.busy_i   (busy_o)
	);

	// ====================================================================
	// reference model
	// ====================================================================
	function automatic int clamp_acc(input int v);
		if (v > ACC_MAX)
			return ACC_MAX;
		if (v < ACC_MIN)
			return ACC_MIN;
		return v;
	endfunction

	task automatic model_tick();
		int a;
		int c;
		int cur;
		int half;
		int full;
		int ri;
		int rq;
		for (int b = 0; b < NUM_BASELINES; b++) begin
			a = pair_a[b];
			c = pair_b[b];
			cur  = model_line[a][0];
			half = model_line[c][lag_ref[c] / 2];
			full = model_line[c][lag_ref[c]];
			if (mask_ref[a] && mask_ref[c]) begin
				ri = cur * half;
				rq = cur * full;
			end else begin
				ri = cur - half;
				rq = cur - full;
			end
			if (enable_ref && acc_i_ref[b] < MAX_COUNTS && acc_q_ref[b] < MAX_COUNTS) begin
				acc_i_ref[b] = clamp_acc(acc_i_ref[b] + ri);
				acc_q_ref[b] = clamp_acc(acc_q_ref[b] + rq);
			end
		end
	endtask

	task automatic clear_model_accs();
		for (int b = 0; b < NUM_BASELINES; b++) begin
			acc_i_ref[b] = 0;
			acc_q_ref[b] = 0;
		end
	endtask

	// ====================================================================
	// stimulus and scoreboard tasks
	// ====================================================================
	task automatic report_mismatch(input string what, input int got_v, input int exp_v);
		error_count++;
		$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got_v, exp_v);
	endtask

	task automatic set_config(input bit enable, input logic [NUM_INPUTS-1:0] mask,
		input logic [NUM_INPUTS*LAG_WIDTH-1:0] lags);
		@(posedge clk);
		#1;
		enable_i  = enable;
		op_mask_i = mask;
		lag_i     = lags;
		enable_ref = enable;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			mask_ref[i] = mask[i];
			lag_ref[i]  = lags[i*LAG_WIDTH +: LAG_WIDTH];
		end
		if (!enable)
			clear_model_accs();
		repeat (2) @(posedge clk);
	endtask

	// toggles the chosen strobes together, which gives one tick
	task automatic toggle_samples(input logic [NUM_INPUTS-1:0] sel,
		input logic [NUM_INPUTS*WORD_WIDTH-1:0] data);
		@(posedge clk);
		#1;
		sample_data_i   = data;
		sample_strobe_i = sample_strobe_i ^ sel;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			if (sel[i]) begin
				for (int t = LINE_DEPTH - 1; t > 0; t--)
					model_line[i][t] = model_line[i][t-1];
				model_line[i][0] = data[i*WORD_WIDTH +: WORD_WIDTH];
			end
		end
		if (sel != '0)
			model_tick();
		repeat (TICK_GAP - 1) @(posedge clk);
	endtask

	task automatic read_dump(input bit random_ready);
		int got;
		int waited;
		got = 0;
		waited = 0;
		repeat (2) @(posedge clk); // lets the last product settle before the snapshot
		#1 dump_i = 1'b1;
		@(posedge clk);
		#1 dump_i = 1'b0;
		// the dump edge has passed, so the snapshot cycle is already busy
		assert (busy_o) else report_mismatch("busy_o after the dump edge", busy_o, 1);
		while (got < NUM_BASELINES && waited < DUMP_LIMIT) begin
			out_ready_i = random_ready ? 1'($random(seed)) : 1'b1;
			@(negedge clk);
			if (out_valid_o && out_ready_i) begin
				assert (out_index_o == got)
					else report_mismatch("out_index_o", out_index_o, got);
				assert (out_i_o == acc_i_ref[got])
					else report_mismatch($sformatf("I of baseline %0d", got), out_i_o, acc_i_ref[got]);
				assert (out_q_o == acc_q_ref[got])
					else report_mismatch($sformatf("Q of baseline %0d", got), out_q_o, acc_q_ref[got]);
				got++;
			end
			@(posedge clk);
			#1;
			waited++;
		end
		out_ready_i = 1'b0;
		if (got < NUM_BASELINES) begin
			error_count++;
			$display("readout stalled: only %0d of %0d words arrived", got, NUM_BASELINES);
		end
		assert (!busy_o) else report_mismatch("busy_o after the last word", busy_o, 0);
		clear_model_accs(); // the dump clears every cell
	endtask

	task automatic print_totals();
		$display("errors: %0d scoreboard, %0d assertion", error_count, UUT.u_checker.fail_count);
	endtask

	// ====================================================================
	// test sequence
	// ====================================================================
	initial begin
		enable_i        = 1'b0;
		sample_strobe_i = '0;
		sample_data_i   = '0;
		lag_i           = '0;
		op_mask_i       = '0;
		dump_i          = 1'b0;
		out_ready_i     = 1'b0;
		enable_ref      = 1'b0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			lag_ref[i]  = 0;
			mask_ref[i] = 1'b0;
			for (int t = 0; t < LINE_DEPTH; t++)
				model_line[i][t] = 0;
		end
		clear_model_accs();
		@(posedge arst_n_i);
		repeat (2) @(posedge clk);

		// disabled cells must read back as zeros
		toggle_samples(4'b1111, 8'b11_10_01_11);
		toggle_samples(4'b0101, 8'h5a);
		read_dump(1'b0);

		// multiply with constant samples and zero lags
		set_config(1'b1, 4'b1111, '0);
		repeat (10) toggle_samples(4'b1111, {2'd2, 2'd3, 2'd2, 2'd1});
		read_dump(1'b0);

		// difference on a ramp, lags 3 5 7 2 for inputs 0 to 3
		set_config(1'b1, 4'b0000, {3'd2, 3'd7, 3'd5, 3'd3});
		for (k = 0; k < 12; k++)
			toggle_samples(4'b1111, {2'(k + 3), 2'(k + 2), 2'(k + 1), 2'(k)});
		read_dump(1'b1);

		// full-scale samples run every accumulator into saturation
		set_config(1'b1, 4'b1111, '0);
		repeat (60) toggle_samples(4'b1111, 8'hff);
		read_dump(1'b0);

		// mixed modes, random strobe subsets and random back-pressure
		set_config(1'b1, 4'b0111, {3'd1, 3'd4, 3'd6, 3'd3});
		repeat (2) begin
			repeat (16) begin
				which = 4'($random(seed));
				if (which == '0)
					which = 4'b1000;
				d = 8'($random(seed));
				toggle_samples(which, d);
			end
			read_dump(1'b1);
		end

		// after the last dump only these new samples may show up
		for (k = 0; k < 5; k++)
			toggle_samples(4'b1111, {2'(k), 2'(3 - k), 2'(k + 1), 2'(2)});
		read_dump(1'b0);

		repeat (5) @(posedge clk);
		print_totals();
		if (error_count == 0 && UUT.u_checker.fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the tick and dump budgets
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
		print_totals();
		$display("Test failures found");
		$finish;
	end

endmodule

/* files.f */
corr_pkg.sv
sample_capture.sv
baseline_cell.sv
readout_serializer.sv
correlator_top.sv
correlator_checker.sv
tb_clock_gen.sv
correlator_tb.sv
